/* GrayCounterBank.f */
hdl/GrayCounterPkg.sv
hdl/CounterIf.sv
hdl/PrefixAnd.sv
hdl/IncGrayC.sv
hdl/EventDecoder.sv
hdl/GrayCounter.sv
hdl/CountReadout.sv
hdl/GrayCounterBank.sv
dv/GrayCounterBankTb.sv

/* Makefile */
# Verilator flow for the Gray counter bank

VERILATOR ?= verilator
TB_TOP    ?= GrayCounterBankTb
RTL_TOP   ?= GrayCounterBank
FILELIST  ?= GrayCounterBank.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	@out="$$($(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/GrayCounterBankTb.sv */
`timescale 1ns/1ns

// table-driven testbench for the Gray counter bank
module GrayCounterBankTb import GrayCounterPkg::*; ();

	localparam int clkPeriod = 4;
	localparam int resetCycles = 4;
	localparam int resetTimeout = 20;
	localparam int randomRows = 3000;
	localparam int rngSeed = 50762;

	// one stimulus row per clock cycle
	typedef struct packed {
		logic clr;
		logic ev;
		chanT evCh;
		chanT rdCh;
	} rowT;

	logic clk;
	logic rstN;
	logic eventValid;
	chanT eventChannel;
	logic clearAll;
	chanT readChannel;
	binT  readCount;
	logic readWrap;

	rowT stim [$];

	// reference state, binary counts and sticky flags
	int   modelCount [numChannels];
	logic modelWrap [numChannels];

	GrayCounterBank UUT (
		.clk(clk),
		.rstN(rstN),
		.eventValid(eventValid),
		.eventChannel(eventChannel),
		.clearAll(clearAll),
		.readChannel(readChannel),
		.readCount(readCount),
		.readWrap(readWrap)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// clock start, idle inputs, reset pulse
	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		eventValid = 1'b0;
		eventChannel = '0;
		clearAll = 1'b0;
		readChannel = '0;
		repeat (resetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

	task automatic checkValue(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("ERR %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "readout mismatch");
		end
	endtask

	task automatic addRow(input logic clr, input logic ev, input int evCh, input int rdCh);
		rowT r;
		r.clr = clr;
		r.ev = ev;
		r.evCh = chanT'(evCh);
		r.rdCh = chanT'(rdCh);
		stim.push_back(r);
	endtask

	task automatic driveRow(input rowT r);
		clearAll = r.clr;
		eventValid = r.ev;
		eventChannel = r.evCh;
		readChannel = r.rdCh;
	endtask

	// one counter step as seen by the counters
	// clear wins over an event in the same row
	task automatic applyModel(input rowT r);
		if (r.clr) begin
			for (int c = 0; c < numChannels; c++) begin
				modelCount[c] = 0;
				modelWrap[c] = 1'b0;
			end
		end else if (r.ev) begin
			if (modelCount[r.evCh] == (1 << countWidth) - 1) begin
				modelWrap[r.evCh] = 1'b1;
			end
			modelCount[r.evCh] = (modelCount[r.evCh] + 1) % (1 << countWidth);
		end
	endtask

	task automatic buildTable();
		logic clr;
		logic ev;
		// fresh after reset
		for (int c = 0; c < numChannels; c++) begin
			addRow(1'b0, 1'b0, 0, c);
		end
		// single event per channel, then read it and its neighbour
		for (int c = 0; c < numChannels; c++) begin
			addRow(1'b0, 1'b1, c, c);
			addRow(1'b0, 1'b0, 0, c);
			addRow(1'b0, 1'b0, 0, c);
			addRow(1'b0, 1'b0, 0, (c + 1) % numChannels);
		end
		// start the lap from zero
		addRow(1'b1, 1'b0, 0, 1);
		// full lap on channel 1 back to zero with the wrap flag set
		for (int i = 0; i < 256; i++) begin
			addRow(1'b0, 1'b1, 1, 1);
		end
		repeat (3) addRow(1'b0, 1'b0, 0, 1);
		// flag must survive more events
		for (int i = 0; i < 5; i++) begin
			addRow(1'b0, 1'b1, 1, 1);
		end
		repeat (3) addRow(1'b0, 1'b0, 0, 1);
		// clear with a competing event on channel 2
		addRow(1'b1, 1'b1, 2, 1);
		for (int c = 0; c < numChannels; c++) begin
			addRow(1'b0, 1'b0, 0, c);
			addRow(1'b0, 1'b0, 0, c);
		end
		// random mix, clears rare enough that counts cross every bit
		for (int i = 0; i < randomRows; i++) begin
			clr = ($urandom % 1000) == 0;
			ev = ($urandom % 4) != 0;
			addRow(clr, ev, $urandom % numChannels, $urandom % numChannels);
		end
		// drain the pipeline
		repeat (3) addRow(1'b0, 1'b0, 0, 0);
	endtask

	initial begin
		int waitCycles;
		void'($urandom(rngSeed));
		for (int c = 0; c < numChannels; c++) begin
			modelCount[c] = 0;
			modelWrap[c] = 1'b0;
		end
		buildTable();

		waitCycles = 0;
		while (rstN !== 1'b1 && waitCycles < resetTimeout) begin
			@(posedge clk);
			waitCycles++;
		end
		if (rstN !== 1'b1) begin
			$display("reset never released after %0d clock cycles", resetTimeout);
			$display("TEST RESULT: FAIL");
			$fatal(1, "reset timeout");
		end

		for (int k = 0; k < stim.size(); k++) begin
			@(posedge clk);
			#1;
			// readout just captured the channel named one row back
			// model still holds the counts from before this edge
			if (k >= 1) begin
				checkValue(int'(readCount), modelCount[stim[k-1].rdCh],
					$sformatf("row %0d count of channel %0d", k - 1, stim[k-1].rdCh));
				checkValue(int'(readWrap), int'(modelWrap[stim[k-1].rdCh]),
					$sformatf("row %0d wrap of channel %0d", k - 1, stim[k-1].rdCh));
			end
			// counters took the row from two edges back
			if (k >= 2) begin
				applyModel(stim[k-2]);
			end
			driveRow(stim[k]);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* hdl/CountReadout.sv */
`timescale 1ns/1ns

// selects one channel and presents its count in binary
module CountReadout import GrayCounterPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  chanT     readChannel,
	CounterIf.reader chans [numChannels],
	output binT      readCount,
	output logic     readWrap
);

	grayT                   counts [numChannels];
	logic [numChannels-1:0] wraps;
	grayT                   selGray;
	binT                    selBin;

	// interface arrays only take constant indices
	// so gather into plain arrays first
	for (genvar i = 0; i < numChannels; i++) begin : gather
		assign counts[i] = chans[i].count;
		assign wraps[i]  = chans[i].wrap;
	end

	// Gray to binary, running xor from the top bit down
	always_comb begin
		selGray = counts[readChannel];
		selBin[countWidth-1] = selGray[countWidth-1];
		for (int i = countWidth - 2; i >= 0; i--) begin
			selBin[i] = selBin[i+1] ^ selGray[i];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			readCount <= '0;
			readWrap  <= 1'b0;
		end else begin
			readCount <= selBin;
			readWrap  <= wraps[readChannel];
		end
	end

	// once a clear has emptied every wrap flag the next readout shows none
	assert property (@(posedge clk) disable iff (!rstN) (wraps == '0) |=> !readWrap);

endmodule

/* hdl/CounterIf.sv */
`timescale 1ns/1ns

// one counter channel between decoder, counter and readout
interface CounterIf import GrayCounterPkg::*; ();

	// single-cycle increment request
	logic inc;
	// single-cycle clear request
	logic clear;
	// current Gray count
	grayT count;
	// sticky wrap indication
	logic wrap;

	modport decoder (output inc, output clear);
	modport counter (input inc, input clear, output count, output wrap);
	modport reader (input count, input wrap);

endinterface

/* hdl/EventDecoder.sv */
`timescale 1ns/1ns

// registers an event and fans it out as per-channel strobes
module EventDecoder import GrayCounterPkg::*; (
	input  logic             clk,
	input  logic             rstN,
	input  logic             eventValid,
	input  chanT             eventChannel,
	input  logic             clearAll,
	CounterIf.decoder        chans [numChannels]
);

	logic [numChannels-1:0] incNext;
	logic [numChannels-1:0] incVec;
	logic                   clearQ;

	// one-hot of the named channel, suppressed by a clear in the same cycle
	always_comb begin
		incNext = '0;
		if (eventValid && !clearAll) begin
			incNext[eventChannel] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			incVec <= '0;
			clearQ <= 1'b0;
		end else begin
			incVec <= incNext;
			clearQ <= clearAll;
		end
	end

	// clear goes to every channel
	for (genvar i = 0; i < numChannels; i++) begin : fanOut
		assign chans[i].inc   = incVec[i];
		assign chans[i].clear = clearQ;
	end

	// only one counter may step per cycle
	assert property (@(posedge clk) disable iff (!rstN) $onehot0(incVec));

endmodule

/* hdl/GrayCounter.sv */
`timescale 1ns/1ns

// one Gray counter channel with sticky wrap flag
module GrayCounter import GrayCounterPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	CounterIf.counter chan
);

	grayT nextCount;
	logic atTop;

	// next code, equal to the current one when inc is low
	IncGrayC #(
		.width(countWidth),
		.speed(prefixSpeed)
	) incrementer (
		.A(chan.count),
		.CI(chan.inc),
		.Z(nextCount)
	);

	// Gray code of all ones
	// only the top bit set
	assign atTop = chan.count[countWidth-1] && (chan.count[countWidth-2:0] == '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			chan.count <= '0;
			chan.wrap  <= 1'b0;
		end else if (chan.clear) begin
			chan.count <= '0;
			chan.wrap  <= 1'b0;
		end else begin
			chan.count <= nextCount;
			// stepping past the top sets the flag until the next clear
			if (chan.inc && atTop) begin
				chan.wrap <= 1'b1;
			end
		end
	end

	// Gray property
	// without a clear the count moves by one bit at most
	assert property (@(posedge clk) disable iff (!rstN)
		!chan.clear |=> $countones(chan.count ^ $past(chan.count)) <= 1);

endmodule

/* hdl/GrayCounterBank.sv */
`timescale 1ns/1ns

// bank of Gray event counters with a single binary readout port
module GrayCounterBank import GrayCounterPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic eventValid,
	input  chanT eventChannel,
	input  logic clearAll,
	input  chanT readChannel,
	output binT  readCount,
	output logic readWrap
);

	// one link per channel
	CounterIf chans [numChannels] ();

	// event in, strobes out
	EventDecoder decoder (
		.clk(clk),
		.rstN(rstN),
		.eventValid(eventValid),
		.eventChannel(eventChannel),
		.clearAll(clearAll),
		.chans(chans)
	);

	// identical counter channels
	for (genvar i = 0; i < numChannels; i++) begin : channel
		GrayCounter counter (
			.clk(clk),
			.rstN(rstN),
			.chan(chans[i])
		);
	end

	// mux, decode and register the selected channel
	CountReadout reader (
		.clk(clk),
		.rstN(rstN),
		.readChannel(readChannel),
		.chans(chans),
		.readCount(readCount),
		.readWrap(readWrap)
	);

endmodule

/* hdl/GrayCounterPkg.sv */
// shared widths and types for the Gray counter bank
package GrayCounterPkg;

	// bits per count
	localparam int countWidth = 8;

	// counter channels in the bank
	localparam int numChannels = 4;

	// bits needed to name a channel
	localparam int chanWidth = $clog2(numChannels);

	// prefix architecture for the incrementer
	// 0 serial, 1 Brent-Kung, 2 Sklansky
	localparam int prefixSpeed = 1;

	// Gray-coded count as held in the counters
	typedef logic [countWidth-1:0] grayT;

	// binary count as presented at the readout
	typedef logic [countWidth-1:0] binT;

	// channel index
	typedef logic [chanWidth-1:0] chanT;

endpackage

/* hdl/IncGrayC.sv */
`timescale 1ns/1ns

// Gray code incrementer with carry-in
// parity of A picks which bit toggles
//   even parity toggles bit 0
//   odd parity toggles the bit above the lowest set bit
module IncGrayC #(
	parameter int width = 16,
	parameter int speed = 1
) (
	input  logic [width-1:0] A,
	input  logic             CI,
	output logic [width-1:0] Z
);

	logic             parity;
	logic             lateGate;
	logic [width-2:0] propIn;
	logic [width-2:0] propOut;
	logic [width-1:0] toggle;

	// parity of the operand
	assign parity = ^A;

	// propagate is high while the lower operand bits stay zero
	assign propIn[width-2:1] = ~A[width-3:0];

	// serial form folds parity into the chain head
	// tree forms apply it after the prefix to keep it off the critical path
	if (speed == 0) begin : earlyParity
		assign propIn[0] = CI & parity;
		assign lateGate  = 1'b1;
	end else begin : lateParity
		assign propIn[0] = CI;
		assign lateGate  = parity;
	end

	// propOut[i] means all operand bits below i are zero
	PrefixAnd #(
		.width(width - 1),
		.speed(speed)
	) prefix (
		.PI(propIn),
		.PO(propOut)
	);

	// bit i toggles when bit i-1 is the lowest set bit
	for (genvar i = 2; i < width - 1; i++) begin : midBits
		assign toggle[i] = A[i-1] & propOut[i-1] & lateGate;
	end

	// top bit also toggles when it is the only one set
	assign toggle[width-1] = propOut[width-2] & lateGate;

	// low two bits decoded directly
	assign toggle[1] = CI & parity & A[0];
	assign toggle[0] = CI & ~parity;

	assign Z = A ^ toggle;

endmodule

/* hdl/PrefixAnd.sv */
`timescale 1ns/1ns

// running AND over the propagate inputs
// PO[i] is the AND of PI[0] up to PI[i]
module PrefixAnd #(
	parameter int width = 8,
	parameter int speed = 1
) (
	input  logic [width-1:0] PI,
	output logic [width-1:0] PO
);

	// tree depth, at least one level so a 1-bit word still elaborates
	localparam int depth = (width > 1) ? $clog2(width) : 1;

	// Sklansky tree
	// each level merges the upper half of every block with the top of its lower half
	if (speed == 2) begin : sklansky
		logic [width-1:0] lvl [0:depth];

		assign lvl[0] = PI;
		for (genvar l = 1; l <= depth; l++) begin : levels
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i >> (l - 1)) % 2 == 1) begin : merge
					assign lvl[l][i] = lvl[l-1][i] & lvl[l-1][((i >> (l - 1)) << (l - 1)) - 1];
				end else begin : pass
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end
		assign PO = lvl[depth];
	end

	// Brent-Kung tree
	// up sweep builds power-of-two groups, down sweep fills the gaps
	if (speed == 1) begin : brentKung
		logic [width-1:0] lvl [0:2*depth-1];

		assign lvl[0] = PI;
		// up sweep, span doubles each level
		for (genvar l = 1; l <= depth; l++) begin : up
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i + 1) % (2 ** l) == 0) begin : merge
					assign lvl[l][i] = lvl[l-1][i] & lvl[l-1][i - 2 ** (l - 1)];
				end else begin : pass
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end
		// down sweep, span halves each level
		for (genvar l = depth + 1; l < 2 * depth; l++) begin : down
			for (genvar i = 0; i < width; i++) begin : bits
				if (i >= 2 ** (2 * depth - l) &&
					(i + 1) % (2 ** (2 * depth - l)) == 2 ** (2 * depth - l - 1)) begin : merge
					assign lvl[l][i] = lvl[l-1][i] & lvl[l-1][i - 2 ** (2 * depth - l - 1)];
				end else begin : pass
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end
		assign PO = lvl[2*depth-1];
	end

	// serial ripple chain
	if (speed == 0) begin : serial
		logic [width-1:0] chain;

		assign chain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign chain[i] = PI[i] & chain[i-1];
		end
		assign PO = chain;
	end

endmodule
